// File: Makefile
# Verilator build and run of the vector modular product testbench

VERILATOR ?= verilator
TOP       ?= ntm_product_tb
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir

SOURCES := $(wildcard source/*.sv) $(wildcard tests/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: build run clean

build: $(BIN)

# Rebuilt only when the file list or a source changes
$(BIN): filelist.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f filelist.f -o V$(TOP)

# Exit status of the simulator is the pass or fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
source/ntm_product_pkg.sv
source/ntm_element_fifo.sv
source/ntm_modular_multiplier.sv
source/ntm_scalar_multiplication_function.sv
source/ntm_product_top.sv
tests/ntm_product_assert.sv
tests/ntm_product_tb.sv

// File: source/ntm_element_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Element FIFO between the input stream and the sequencing function
// Circular buffer with read/write pointers and occupancy count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_element_fifo (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   DATA_IN_ENABLE,
  input  ntm_product_pkg::data_t DATA_IN,
  input  logic                   fifo_pop,
  output ntm_product_pkg::data_t fifo_data,
  output logic                   fifo_empty,
  output logic                   DATA_IN_FULL
);

  ntm_product_pkg::data_t mem [ntm_product_pkg::FIFO_DEPTH];

  logic [ntm_product_pkg::FIFO_PTR_SIZE-1:0]   wr_ptr;
  logic [ntm_product_pkg::FIFO_PTR_SIZE-1:0]   rd_ptr;
  logic [ntm_product_pkg::FIFO_COUNT_SIZE-1:0] count;

  logic wr_en;
  logic rd_en;

  // Pointer advance with wrap, depth need not be a power of two
  function automatic logic [ntm_product_pkg::FIFO_PTR_SIZE-1:0] next_ptr(
    input logic [ntm_product_pkg::FIFO_PTR_SIZE-1:0] ptr
  );
    if (ptr == ntm_product_pkg::FIFO_PTR_SIZE'(ntm_product_pkg::FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Status straight from the count
  assign fifo_empty   = (count == '0);
  assign DATA_IN_FULL = (count == ntm_product_pkg::FIFO_COUNT_SIZE'(ntm_product_pkg::FIFO_DEPTH));

  // Writes while full and pops while empty are dropped
  assign wr_en = DATA_IN_ENABLE && !DATA_IN_FULL;
  assign rd_en = fifo_pop && !fifo_empty;

  // Head element, visible the cycle after its write
  assign fifo_data = mem[rd_ptr];

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= DATA_IN;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous write and pop leaves the count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/ntm_modular_multiplier.sv
////////////////////////////////////////////////////////////////////////////
// Bit-serial interleaved modular multiplier, MSB of mul_a first
// START/READY handshake, result valid in the mul_ready cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_modular_multiplier (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   mul_start,
  output logic                   mul_ready,
  input  ntm_product_pkg::data_t mul_modulo,
  input  ntm_product_pkg::data_t mul_a,
  input  ntm_product_pkg::data_t mul_b,
  output ntm_product_pkg::data_t mul_result
);

  // Control
  logic                                  busy;
  logic [ntm_product_pkg::STEP_SIZE-1:0] step_cnt;
  logic                                  last_step;

  // Latched operands and partial sum
  ntm_product_pkg::data_t a_reg;
  ntm_product_pkg::data_t b_reg;
  ntm_product_pkg::data_t m_reg;
  ntm_product_pkg::data_t acc;

  // One step of the recurrence
  ntm_product_pkg::wide_t acc_dbl;
  ntm_product_pkg::wide_t acc_add;
  ntm_product_pkg::wide_t acc_next;

  // Conditional subtract, input is always below twice the modulus
  function automatic ntm_product_pkg::wide_t reduce(
    input ntm_product_pkg::wide_t x,
    input ntm_product_pkg::data_t m
  );
    if (x >= {1'b0, m}) begin
      return x - {1'b0, m};
    end
    return x;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Datapath step
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Double, then fold back under the modulus
    acc_dbl = reduce({acc, 1'b0}, m_reg);
    // Add b only for a one bit
    acc_add = reduce(acc_dbl + {1'b0, b_reg}, m_reg);
    acc_next = a_reg[ntm_product_pkg::DATA_SIZE-1] ? acc_add : acc_dbl;
  end

  assign last_step = (step_cnt == ntm_product_pkg::STEP_SIZE'(ntm_product_pkg::DATA_SIZE - 1));

  // Partial sum is the result once all bits are in
  assign mul_result = acc;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      step_cnt  <= '0;
      mul_ready <= 1'b0;
    end else begin
      mul_ready <= 1'b0;
      if (!busy) begin
        if (mul_start) begin
          busy     <= 1'b1;
          step_cnt <= '0;
        end
      end else begin
        step_cnt <= step_cnt + 1'b1;
        // Ready lands DATA_SIZE+1 cycles after start
        if (last_step) begin
          busy      <= 1'b0;
          mul_ready <= 1'b1;
        end
      end
    end
  end

  // Operands and accumulator
  always_ff @(posedge CLK) begin
    if (!busy && mul_start) begin
      a_reg <= mul_a;
      b_reg <= mul_b;
      m_reg <= mul_modulo;
      acc   <= '0;
    end else if (busy) begin
      a_reg <= a_reg << 1;
      acc   <= acc_next[ntm_product_pkg::DATA_SIZE-1:0];
    end
  end

endmodule

`default_nettype wire

// File: source/ntm_product_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, types and FSM encoding of the vector modular product
// Element buffer depth and derived pointer/counter widths
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package ntm_product_pkg;

  // Element, modulus and product width
  localparam int DATA_SIZE = 16;
  // Length and loop index width
  localparam int INDEX_SIZE = 8;

  // Element buffer
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_SIZE = $clog2(FIFO_DEPTH);
  localparam int FIFO_COUNT_SIZE = $clog2(FIFO_DEPTH + 1);

  // Multiplier bit step counter
  localparam int STEP_SIZE = $clog2(DATA_SIZE);

  typedef logic [DATA_SIZE-1:0] data_t;
  typedef logic [INDEX_SIZE-1:0] index_t;
  // One spare bit for doubling and adding before reduction
  typedef logic [DATA_SIZE:0] wide_t;

  typedef enum logic [1:0] {
    STARTER_STATE = 2'd0,
    INPUT_STATE   = 2'd1,
    ENDER_STATE   = 2'd2
  } fsm_state_t;

endpackage

`default_nettype wire

// File: source/ntm_product_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the vector modular product
// Element FIFO, sequencing FSM and bit-serial multiplier
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_product_top (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    START,
  output logic                    READY,
  input  ntm_product_pkg::index_t LENGTH_IN,
  input  ntm_product_pkg::data_t  MODULO_IN,
  input  logic                    DATA_IN_ENABLE,
  input  ntm_product_pkg::data_t  DATA_IN,
  output logic                    DATA_IN_FULL,
  output ntm_product_pkg::data_t  DATA_OUT,
  output logic                    DATA_OUT_ENABLE
);

  // FIFO to function
  logic                   fifo_empty;
  logic                   fifo_pop;
  ntm_product_pkg::data_t fifo_data;

  // Function to multiplier
  logic                   mul_start;
  logic                   mul_ready;
  ntm_product_pkg::data_t mul_a;
  ntm_product_pkg::data_t mul_b;
  ntm_product_pkg::data_t mul_modulo;
  ntm_product_pkg::data_t mul_result;

  ntm_element_fifo u_fifo (
    .CLK            (CLK),
    .RST            (RST),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_IN        (DATA_IN),
    .fifo_pop       (fifo_pop),
    .fifo_data      (fifo_data),
    .fifo_empty     (fifo_empty),
    .DATA_IN_FULL   (DATA_IN_FULL)
  );

  ntm_scalar_multiplication_function u_function (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .READY           (READY),
    .LENGTH_IN       (LENGTH_IN),
    .MODULO_IN       (MODULO_IN),
    .fifo_empty      (fifo_empty),
    .fifo_data       (fifo_data),
    .fifo_pop        (fifo_pop),
    .mul_start       (mul_start),
    .mul_ready       (mul_ready),
    .mul_result      (mul_result),
    .mul_a           (mul_a),
    .mul_b           (mul_b),
    .mul_modulo      (mul_modulo),
    .DATA_OUT        (DATA_OUT),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE)
  );

  ntm_modular_multiplier u_multiplier (
    .CLK        (CLK),
    .RST        (RST),
    .mul_start  (mul_start),
    .mul_ready  (mul_ready),
    .mul_modulo (mul_modulo),
    .mul_a      (mul_a),
    .mul_b      (mul_b),
    .mul_result (mul_result)
  );

endmodule

`default_nettype wire

// File: source/ntm_scalar_multiplication_function.sv
////////////////////////////////////////////////////////////////////////////
// Sequencing FSM for the vector modular product
// Pops elements, drives the multiplier, emits each running product
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_multiplication_function (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    START,
  output logic                    READY,
  input  ntm_product_pkg::index_t LENGTH_IN,
  input  ntm_product_pkg::data_t  MODULO_IN,
  input  logic                    fifo_empty,
  input  ntm_product_pkg::data_t  fifo_data,
  output logic                    fifo_pop,
  output logic                    mul_start,
  input  logic                    mul_ready,
  input  ntm_product_pkg::data_t  mul_result,
  output ntm_product_pkg::data_t  mul_a,
  output ntm_product_pkg::data_t  mul_b,
  output ntm_product_pkg::data_t  mul_modulo,
  output ntm_product_pkg::data_t  DATA_OUT,
  output logic                    DATA_OUT_ENABLE
);

  ntm_product_pkg::fsm_state_t state;

  // Loop control
  ntm_product_pkg::index_t index_loop;
  ntm_product_pkg::index_t length_reg;

  // Decoded events
  logic start_accept;
  logic step_done;
  logic last_element;

  // START only counts while idle
  assign start_accept = (state == ntm_product_pkg::STARTER_STATE) && START;

  // Head consumed in the cycle it is seen
  assign fifo_pop = (state == ntm_product_pkg::INPUT_STATE) && !fifo_empty;

  assign step_done    = (state == ntm_product_pkg::ENDER_STATE) && mul_ready;
  assign last_element = (index_loop == length_reg - 1'b1);

  ////////////////////////////////////////////////////////////////////////////
  // FSM and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ntm_product_pkg::STARTER_STATE;
      index_loop      <= '0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
      mul_start       <= 1'b0;
    end else begin
      // Pulses by default
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      mul_start       <= 1'b0;
      case (state)
        ntm_product_pkg::STARTER_STATE: begin
          if (start_accept) begin
            index_loop <= '0;
            state      <= ntm_product_pkg::INPUT_STATE;
          end
        end
        ntm_product_pkg::INPUT_STATE: begin
          // Stall here until an element is buffered
          if (fifo_pop) begin
            mul_start <= 1'b1;
            state     <= ntm_product_pkg::ENDER_STATE;
          end
        end
        ntm_product_pkg::ENDER_STATE: begin
          if (step_done) begin
            DATA_OUT        <= mul_result;
            DATA_OUT_ENABLE <= 1'b1;
            if (last_element) begin
              // READY goes with the final product
              READY <= 1'b1;
              state <= ntm_product_pkg::STARTER_STATE;
            end else begin
              index_loop <= index_loop + 1'b1;
              state      <= ntm_product_pkg::INPUT_STATE;
            end
          end
        end
        default: begin
          state <= ntm_product_pkg::STARTER_STATE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operands, held steady for the multiplier
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start_accept) begin
      length_reg <= LENGTH_IN;
      mul_modulo <= MODULO_IN;
      // Product starts at 1, modulus is at least 2
      mul_b      <= ntm_product_pkg::data_t'(1);
    end
    // Element reaches the multiplier one cycle after the pop
    if (fifo_pop) begin
      mul_a <= fifo_data;
    end
    // Running product
    if (step_done) begin
      mul_b <= mul_result;
    end
  end

endmodule

`default_nettype wire

// File: tests/ntm_product_assert.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions on the top-level handshakes
// Bound into the vector modular product top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_product_assert (
  input logic                   CLK,
  input logic                   RST,
  input logic                   READY,
  input logic                   DATA_OUT_ENABLE,
  input ntm_product_pkg::data_t DATA_OUT,
  input ntm_product_pkg::data_t mul_modulo,
  input logic                   DATA_IN_ENABLE,
  input logic                   DATA_IN_FULL
);

  // READY is a single-cycle pulse
  ready_one_cycle: assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else $error("READY held for more than one cycle");

  // Every running product is reduced under the latched modulus
  product_below_modulus: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |-> (DATA_OUT < mul_modulo))
    else $error("DATA_OUT not below the modulus");

  // No writes into a full buffer
  no_write_when_full: assert property (@(posedge CLK) disable iff (RST)
    !(DATA_IN_ENABLE && DATA_IN_FULL))
    else $error("DATA_IN_ENABLE high while DATA_IN_FULL");

endmodule

bind ntm_product_top ntm_product_assert u_assert (
  .CLK             (CLK),
  .RST             (RST),
  .READY           (READY),
  .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
  .DATA_OUT        (DATA_OUT),
  .mul_modulo      (mul_modulo),
  .DATA_IN_ENABLE  (DATA_IN_ENABLE),
  .DATA_IN_FULL    (DATA_IN_FULL)
);

`default_nettype wire

// File: tests/ntm_product_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the vector modular product top level
// Random vectors from a fixed seed, running product model, compare tasks
// Cycle counter timeout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_product_tb;

  localparam int NUM_TESTS = 40;
  localparam int MAX_LEN = 12;
  // Worst case per element is a pop, a start, the multiply and the output
  localparam int CYCLE_LIMIT = NUM_TESTS * MAX_LEN * (ntm_product_pkg::DATA_SIZE + 10) + 2000;

  logic                    CLK;
  logic                    RST;
  logic                    START;
  logic                    READY;
  ntm_product_pkg::index_t LENGTH_IN;
  ntm_product_pkg::data_t  MODULO_IN;
  logic                    DATA_IN_ENABLE;
  ntm_product_pkg::data_t  DATA_IN;
  logic                    DATA_IN_FULL;
  ntm_product_pkg::data_t  DATA_OUT;
  logic                    DATA_OUT_ENABLE;

  // Model state
  ntm_product_pkg::data_t  exp_q [$];
  ntm_product_pkg::data_t  elems [$];
  ntm_product_pkg::data_t  expected;
  ntm_product_pkg::data_t  final_prod;
  ntm_product_pkg::index_t cur_len;
  ntm_product_pkg::index_t out_count;
  int                      vectors_done = 0;
  int                      cycle_count = 0;
  string                   test_name = "reset";

  ntm_product_top uut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .READY           (READY),
    .LENGTH_IN       (LENGTH_IN),
    .MODULO_IN       (MODULO_IN),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_IN         (DATA_IN),
    .DATA_IN_FULL    (DATA_IN_FULL),
    .DATA_OUT        (DATA_OUT),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE)
  );

  always #10 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // Next running product, wide enough for the full 32-bit product
  function automatic ntm_product_pkg::data_t model_step(input ntm_product_pkg::data_t prev,
                                                        input ntm_product_pkg::data_t elem,
                                                        input ntm_product_pkg::data_t modulus);
    logic [31:0] prod;
    prod = 32'(prev) * 32'(elem);
    return ntm_product_pkg::data_t'(prod % 32'(modulus));
  endfunction

  task automatic fail_now(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input string name, input ntm_product_pkg::data_t exp,
                            input ntm_product_pkg::data_t act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED %s DATA_OUT: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // READY must sit on the last product
  task automatic check_ready(input string name, input ntm_product_pkg::data_t exp,
                             input logic ready, input ntm_product_pkg::data_t act);
    if (ready !== 1'b1) begin
      fail_now($sformatf("%s: READY did not pulse with the last product", name));
    end else if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED %s READY product: expected %0d, actual %0d",
                         name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input ntm_product_pkg::index_t exp,
                             input ntm_product_pkg::index_t act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED %s output count: expected %0d, actual %0d",
                         name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED %s: expected %0b, actual %0b", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (READY && !DATA_OUT_ENABLE) begin
        fail_now($sformatf("%s: READY rose without DATA_OUT_ENABLE", test_name));
      end else if (DATA_OUT_ENABLE && exp_q.size() == 0) begin
        fail_now($sformatf("%s: DATA_OUT_ENABLE with no product expected", test_name));
      end else if (DATA_OUT_ENABLE) begin
        expected = exp_q.pop_front();
        out_count = ntm_product_pkg::index_t'(out_count + 1);
        check_data(test_name, expected, DATA_OUT);
        // End of vector, expected or signalled early by READY
        if (READY || exp_q.size() == 0) begin
          check_ready(test_name, final_prod, READY, DATA_OUT);
          check_count(test_name, cur_len, out_count);
          out_count = '0;
          vectors_done = vectors_done + 1;
        end
      end
    end
  end

  // Run limit
  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      fail_now($sformatf("Timeout after %0d cycles waiting for the DUT", cycle_count));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, driven 1 ns after the rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  // Hold off while the buffer is full
  task automatic write_element(input ntm_product_pkg::data_t value);
    while (DATA_IN_FULL) begin
      idle_cycles(1);
    end
    DATA_IN_ENABLE = 1'b1;
    DATA_IN = value;
    idle_cycles(1);
    DATA_IN_ENABLE = 1'b0;
  endtask

  task automatic pulse_start(input ntm_product_pkg::index_t len,
                             input ntm_product_pkg::data_t modulus);
    START = 1'b1;
    LENGTH_IN = len;
    MODULO_IN = modulus;
    idle_cycles(1);
    START = 1'b0;
  endtask

  task automatic wait_ready();
    while (!READY) begin
      idle_cycles(1);
    end
  endtask

  task automatic run_vector(input int t);
    ntm_product_pkg::data_t  modulus;
    ntm_product_pkg::data_t  prod;
    ntm_product_pkg::data_t  e;
    ntm_product_pkg::index_t len;
    int                      pre;
    int                      limit;
    int                      r;
    bit                      back_to_back;
    bit                      burst;
    test_name = $sformatf("vector %0d", t);
    // Modulus extremes on the first vectors
    case (t)
      1:       modulus = ntm_product_pkg::data_t'(2);
      2:       modulus = '1;
      default: modulus = ntm_product_pkg::data_t'(2 + ($urandom % 65534));
    endcase
    if (t == 0) begin
      len = ntm_product_pkg::index_t'(1);
    end else if (t == 3) begin
      len = ntm_product_pkg::index_t'(MAX_LEN);
    end else begin
      len = ntm_product_pkg::index_t'(1 + ($urandom % MAX_LEN));
    end
    back_to_back = (t > 3) && ($urandom % 3 == 0);
    burst = (t == 3) || ($urandom % 2 == 0);
    // Elements with zero and modulus-1 mixed in
    elems.delete();
    prod = ntm_product_pkg::data_t'(1);
    for (int i = 0; i < int'(len); i++) begin
      r = $urandom % 8;
      if (r == 0) begin
        e = '0;
      end else if (r == 1 || t == 2) begin
        e = ntm_product_pkg::data_t'(modulus - 1);
      end else begin
        e = ntm_product_pkg::data_t'($urandom % 32'(modulus));
      end
      prod = model_step(prod, e, modulus);
      exp_q.push_back(prod);
      elems.push_back(e);
    end
    final_prod = prod;
    cur_len = len;
    pre = 0;
    if (!back_to_back) begin
      idle_cycles(1 + ($urandom % 3));
      limit = (int'(len) < ntm_product_pkg::FIFO_DEPTH) ? int'(len) : ntm_product_pkg::FIFO_DEPTH;
      pre = (t == 3) ? limit : int'($urandom % (limit + 1));
    end
    // Buffered ahead of START
    for (int i = 0; i < pre; i++) begin
      write_element(elems[i]);
    end
    if (pre == ntm_product_pkg::FIFO_DEPTH) begin
      check_flag({test_name, " DATA_IN_FULL"}, 1'b1, DATA_IN_FULL);
    end
    pulse_start(len, modulus);
    for (int i = pre; i < int'(len); i++) begin
      if (!burst) begin
        idle_cycles($urandom % 4);
      end
      write_element(elems[i]);
    end
    wait_ready();
    // Next vector may start in the cycle after READY
    idle_cycles(1);
  endtask

  initial begin
    void'($urandom(32'haff2));
    CLK = 1'b0;
    RST = 1'b1;
    START = 1'b0;
    LENGTH_IN = '0;
    MODULO_IN = '0;
    DATA_IN_ENABLE = 1'b0;
    DATA_IN = '0;
    out_count = '0;
    cur_len = '0;
    final_prod = '0;
    idle_cycles(8);
    RST = 1'b0;
    // Quiet outputs after reset
    check_flag("reset READY", 1'b0, READY);
    check_flag("reset DATA_OUT_ENABLE", 1'b0, DATA_OUT_ENABLE);
    check_flag("reset DATA_IN_FULL", 1'b0, DATA_IN_FULL);
    check_data("reset", '0, DATA_OUT);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_vector(t);
    end
    idle_cycles(2);
    if (vectors_done == NUM_TESTS && exp_q.size() == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_now($sformatf("Only %0d of %0d vectors completed", vectors_done, NUM_TESTS));
    end
  end

endmodule

`default_nettype wire
